// File: src/fft_consts.svh
// FFT offload engine constants: register map, feature list and datapath widths
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// ====================
// Datapath geometry
// ====================

// Buffer descriptors, 0 is input and 1 is output
`define FFT_HC_BUFFER_SIZE 2

// One cache line per memory beat
`define FFT_LINE_BITS 512
`define FFT_SAMPLES_PER_LINE 16
// Width of one real or imaginary component
`define FFT_SAMPLE_BITS 16

// Line index inside a buffer
`define FFT_TAG_BITS 16

// Byte address to cache-line address
`define FFT_DSM_LINE_SHIFT 6

// ====================
// Register byte offsets
// ====================
`define FFT_REG_DFH       16'h000
`define FFT_REG_AFU_ID_L  16'h008
`define FFT_REG_AFU_ID_H  16'h010
`define FFT_REG_CONTROL   16'h020
`define FFT_REG_DSM_BASE  16'h028
`define FFT_REG_BUF0_ADDR 16'h030
`define FFT_REG_BUF0_SIZE 16'h038
`define FFT_REG_BUF1_ADDR 16'h040
`define FFT_REG_BUF1_SIZE 16'h048
// Read only
`define FFT_REG_STATUS    16'h050

// Feature header fields
`define FFT_DFH_TYPE_AFU 4'h1
`define FFT_DFH_EOL_BIT  40

// Unique accelerator ID, two 64-bit halves
`define FFT_AFU_ID_LOW  64'h8f3a_1c27_d4e6_05b9
`define FFT_AFU_ID_HIGH 64'h6b21_e9c4_77d0_4a13

`endif

// File: src/fft_pkg.sv
// FFT offload engine shared types for channels, registers and job control
`default_nettype none

package fft_pkg;

`include "fft_consts.svh"

  // ====================
  // Scalar types
  // ====================

  // Cache-line address
  typedef logic [41:0] cl_addr_t;
  // MMIO address in 32-bit word units
  typedef logic [15:0] mmio_addr_t;
  typedef logic [63:0] mmio_data_t;
  // Host transaction id
  typedef logic [8:0] tid_t;
  typedef logic [`FFT_LINE_BITS-1:0] line_t;
  // One signed component of a complex sample
  typedef logic signed [`FFT_SAMPLE_BITS-1:0] sample_t;
  typedef logic [`FFT_TAG_BITS-1:0] line_tag_t;

  // ====================
  // Register layouts
  // ====================

  typedef struct packed {
    logic [30:0] rsvd;
    logic        start;
  } hc_control_t;

  // Address and size both count cache lines
  typedef struct packed {
    cl_addr_t    address;
    logic [31:0] size;
  } hc_buffer_t;

  typedef struct packed {
    logic [29:0] rsvd;
    logic        busy;
    logic        done;
    logic [31:0] lines_done;
  } hc_status_t;

  // ====================
  // Channels
  // ====================

  // Host to engine, reads and writes share one header
  typedef struct packed {
    logic       rd_valid;
    logic       wr_valid;
    mmio_addr_t address;
    tid_t       tid;
    mmio_data_t data;
  } mmio_rx_t;

  // Read response back to host
  typedef struct packed {
    logic       rd_valid;
    tid_t       tid;
    mmio_data_t data;
  } mmio_tx_t;

  typedef struct packed {
    logic      valid;
    cl_addr_t  address;
    line_tag_t tag;
  } mem_rd_req_t;

  // Tag comes back with the line, order not guaranteed
  typedef struct packed {
    logic      valid;
    line_tag_t tag;
    line_t     data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t address;
    line_t    data;
  } mem_wr_req_t;

  // Job sequencer states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DSM,
    DONE
  } job_state_t;

endpackage

`default_nettype wire

// File: src/fft_butterfly.sv
// Radix-2 DIF first-stage butterfly over the sixteen complex samples of a line
`timescale 1ns/1ns
`default_nettype none

`include "fft_consts.svh"

module fft_butterfly (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  fft_pkg::line_tag_t in_tag,
  input  fft_pkg::line_t     in_data,
  output logic               out_valid,
  output fft_pkg::line_tag_t out_tag,
  output fft_pkg::line_t     out_data
);

  // Sample k sits at bits 32k, real in the low half, imaginary in the high half
  localparam int CW = 2 * `FFT_SAMPLE_BITS;
  localparam int HALF = `FFT_SAMPLES_PER_LINE / 2;

  fft_pkg::line_t bf_line;

  // Pair k with k+8, sum low, difference high
  for (genvar k = 0; k < HALF; k++) begin : g_pair
    fft_pkg::sample_t a_re;
    fft_pkg::sample_t a_im;
    fft_pkg::sample_t b_re;
    fft_pkg::sample_t b_im;

    assign a_re = in_data[CW * k +: `FFT_SAMPLE_BITS];
    assign a_im = in_data[CW * k + `FFT_SAMPLE_BITS +: `FFT_SAMPLE_BITS];
    assign b_re = in_data[CW * (k + HALF) +: `FFT_SAMPLE_BITS];
    assign b_im = in_data[CW * (k + HALF) + `FFT_SAMPLE_BITS +: `FFT_SAMPLE_BITS];

    // Results truncate to 16 bits so overflow wraps
    assign bf_line[CW * k +: `FFT_SAMPLE_BITS] = a_re + b_re;
    assign bf_line[CW * k + `FFT_SAMPLE_BITS +: `FFT_SAMPLE_BITS] = a_im + b_im;
    assign bf_line[CW * (k + HALF) +: `FFT_SAMPLE_BITS] = a_re - b_re;
    assign bf_line[CW * (k + HALF) + `FFT_SAMPLE_BITS +: `FFT_SAMPLE_BITS] = a_im - b_im;
  end

  // Payload follows the strobe
  always_ff @(posedge clk) begin
    out_tag <= in_tag;
    out_data <= bf_line;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

`default_nettype wire

// File: src/fft_csr.sv
// FFT engine register block serving the feature list, configuration and status over MMIO
`timescale 1ns/1ns
`default_nettype none

`include "fft_consts.svh"

module fft_csr (
  input  logic                                           clk,
  input  logic                                           reset,
  input  fft_pkg::mmio_rx_t                              mmio_rx,
  input  fft_pkg::hc_status_t                            status,
  output fft_pkg::mmio_tx_t                              mmio_tx,
  output fft_pkg::hc_control_t                           hc_control,
  output fft_pkg::cl_addr_t                              hc_dsm_base,
  output fft_pkg::hc_buffer_t [`FFT_HC_BUFFER_SIZE-1:0] hc_buffer
);

  // Word offset of the first descriptor
  // Each descriptor spans 4 words
  localparam fft_pkg::mmio_addr_t BUF_WORD_BASE = `FFT_REG_BUF0_ADDR >> 2;

  // Single AFU entry and last in the list
  localparam fft_pkg::mmio_data_t DFH_WORD = {`FFT_DFH_TYPE_AFU, 60'(1) << `FFT_DFH_EOL_BIT};

  fft_pkg::mmio_data_t rd_data;
  fft_pkg::mmio_addr_t buf_rel;

  // ====================
  // Read decode
  // ====================

  // Register offsets are bytes while the bus carries 32-bit word addresses
  always_comb begin
    case (mmio_rx.address)
      (`FFT_REG_DFH >> 2):       rd_data = DFH_WORD;
      (`FFT_REG_AFU_ID_L >> 2):  rd_data = `FFT_AFU_ID_LOW;
      (`FFT_REG_AFU_ID_H >> 2):  rd_data = `FFT_AFU_ID_HIGH;
      (`FFT_REG_CONTROL >> 2):   rd_data = fft_pkg::mmio_data_t'(hc_control);
      // Read back in line units
      (`FFT_REG_DSM_BASE >> 2):  rd_data = fft_pkg::mmio_data_t'(hc_dsm_base);
      (`FFT_REG_BUF0_ADDR >> 2): rd_data = fft_pkg::mmio_data_t'(hc_buffer[0].address);
      (`FFT_REG_BUF0_SIZE >> 2): rd_data = fft_pkg::mmio_data_t'(hc_buffer[0].size);
      (`FFT_REG_BUF1_ADDR >> 2): rd_data = fft_pkg::mmio_data_t'(hc_buffer[1].address);
      (`FFT_REG_BUF1_SIZE >> 2): rd_data = fft_pkg::mmio_data_t'(hc_buffer[1].size);
      (`FFT_REG_STATUS >> 2):    rd_data = fft_pkg::mmio_data_t'(status);
      // Reserved feature words and unmapped space read as zero
      default:                   rd_data = '0;
    endcase
  end

  // One response per request one cycle later with the same tid
  always_ff @(posedge clk) begin
    mmio_tx.tid <= mmio_rx.tid;
    mmio_tx.data <= rd_data;
    if (reset) begin
      mmio_tx.rd_valid <= 1'b0;
    end else begin
      mmio_tx.rd_valid <= mmio_rx.rd_valid;
    end
  end

  // ====================
  // Write capture
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      hc_control <= '0;
    end else if (mmio_rx.wr_valid && mmio_rx.address == (`FFT_REG_CONTROL >> 2)) begin
      hc_control <= fft_pkg::hc_control_t'(mmio_rx.data[31:0]);
    end
  end

  // Host writes a byte address and the engine keeps a line address
  always_ff @(posedge clk) begin
    if (reset) begin
      hc_dsm_base <= '0;
    end else if (mmio_rx.wr_valid && mmio_rx.address == (`FFT_REG_DSM_BASE >> 2)) begin
      hc_dsm_base <= fft_pkg::cl_addr_t'(mmio_rx.data >> `FFT_DSM_LINE_SHIFT);
    end
  end

  // Word offset inside the descriptor window
  assign buf_rel = mmio_rx.address - BUF_WORD_BASE;

  // Buffer index from bits above 2 and field from bit 1
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `FFT_HC_BUFFER_SIZE; i++) begin
        hc_buffer[i] <= '0;
      end
    end else if (mmio_rx.wr_valid) begin
      for (int i = 0; i < `FFT_HC_BUFFER_SIZE; i++) begin
        if (buf_rel == fft_pkg::mmio_addr_t'(4 * i)) begin
          // Already in line units
          hc_buffer[i].address <= fft_pkg::cl_addr_t'(mmio_rx.data);
        end
        if (buf_rel == fft_pkg::mmio_addr_t'(4 * i + 2)) begin
          hc_buffer[i].size <= mmio_rx.data[31:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/fft_job_ctrl.sv
// FFT job sequencer: line reads, butterfly results to output buffer, completion record
`timescale 1ns/1ns
`default_nettype none

`include "fft_consts.svh"

module fft_job_ctrl (
  input  logic                                           clk,
  input  logic                                           reset,
  input  fft_pkg::hc_control_t                           hc_control,
  input  fft_pkg::cl_addr_t                              hc_dsm_base,
  input  fft_pkg::hc_buffer_t [`FFT_HC_BUFFER_SIZE-1:0] hc_buffer,
  input  logic                                           mem_rd_full,
  input  fft_pkg::mem_rd_rsp_t                           mem_rd_rsp,
  output fft_pkg::mem_rd_req_t                           mem_rd_req,
  output fft_pkg::mem_wr_req_t                           mem_wr_req,
  output fft_pkg::hc_status_t                            status
);

  localparam int IN_BUF = 0;
  localparam int OUT_BUF = 1;

  fft_pkg::job_state_t state;
  logic                start_q;
  logic                start_edge;
  logic                issue_go;
  logic [31:0]         job_size;
  logic [31:0]         issue_cnt;
  logic [31:0]         wr_cnt;

  logic                bf_valid;
  fft_pkg::line_tag_t  bf_tag;
  fft_pkg::line_t      bf_data;

  // ====================
  // Control FSM
  // ====================

  assign start_edge = hc_control.start && !start_q;

  // Full seen this cycle blocks the request of the next cycle
  assign issue_go = (state == fft_pkg::RUN) && (issue_cnt < job_size) && !mem_rd_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_pkg::IDLE;
      start_q <= 1'b0;
      job_size <= '0;
      issue_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      start_q <= hc_control.start;
      if (issue_go) begin
        issue_cnt <= issue_cnt + 32'd1;
      end
      if (bf_valid) begin
        wr_cnt <= wr_cnt + 32'd1;
      end
      case (state)
        fft_pkg::IDLE, fft_pkg::DONE: begin
          // New job, size latched so lines_done compares against it
          if (start_edge) begin
            job_size <= hc_buffer[IN_BUF].size;
            issue_cnt <= '0;
            wr_cnt <= '0;
            state <= (hc_buffer[IN_BUF].size == '0) ? fft_pkg::DSM : fft_pkg::RUN;
          end
        end
        fft_pkg::RUN: begin
          // Every line written back
          if (wr_cnt == job_size) begin
            state <= fft_pkg::DSM;
          end
        end
        // Completion write lasts exactly one cycle
        fft_pkg::DSM: state <= fft_pkg::DONE;
        default: state <= fft_pkg::IDLE;
      endcase
    end
  end

  // ====================
  // Read channel
  // ====================

  always_ff @(posedge clk) begin
    if (issue_go) begin
      mem_rd_req.address <= hc_buffer[IN_BUF].address + fft_pkg::cl_addr_t'(issue_cnt);
      mem_rd_req.tag <= fft_pkg::line_tag_t'(issue_cnt);
    end
    if (reset) begin
      mem_rd_req.valid <= 1'b0;
    end else begin
      mem_rd_req.valid <= issue_go;
    end
  end

  // Returned lines go straight in, tag rides along
  fft_butterfly u_butterfly (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (mem_rd_rsp.valid),
    .in_tag    (mem_rd_rsp.tag),
    .in_data   (mem_rd_rsp.data),
    .out_valid (bf_valid),
    .out_tag   (bf_tag),
    .out_data  (bf_data)
  );

  // ====================
  // Write channel
  // ====================

  // No data writes remain once in DSM, so the two sources never collide
  always_comb begin
    if (state == fft_pkg::DSM) begin
      mem_wr_req.valid = 1'b1;
      mem_wr_req.address = hc_dsm_base;
      // Done flag in the low word, line count above it
      mem_wr_req.data = fft_pkg::line_t'({job_size, 32'd1});
    end else begin
      mem_wr_req.valid = bf_valid;
      mem_wr_req.address = hc_buffer[OUT_BUF].address + fft_pkg::cl_addr_t'(bf_tag);
      mem_wr_req.data = bf_data;
    end
  end

  // Status seen by the host
  always_comb begin
    status.rsvd = '0;
    status.busy = (state == fft_pkg::RUN) || (state == fft_pkg::DSM);
    status.done = (state == fft_pkg::DONE);
    status.lines_done = wr_cnt;
  end

endmodule

`default_nettype wire

// File: src/fft_afu_top.sv
// FFT accelerator function top: register block and job sequencer on MMIO and memory channels
`timescale 1ns/1ns
`default_nettype none

`include "fft_consts.svh"

module fft_afu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  fft_pkg::mmio_rx_t    mmio_rx,
  output fft_pkg::mmio_tx_t    mmio_tx,
  input  logic                 mem_rd_full,
  input  fft_pkg::mem_rd_rsp_t mem_rd_rsp,
  output fft_pkg::mem_rd_req_t mem_rd_req,
  output fft_pkg::mem_wr_req_t mem_wr_req
);

  // Configuration from the host
  fft_pkg::hc_control_t                           hc_control;
  fft_pkg::cl_addr_t                              hc_dsm_base;
  fft_pkg::hc_buffer_t [`FFT_HC_BUFFER_SIZE-1:0] hc_buffer;
  // Progress back to the host
  fft_pkg::hc_status_t                            hc_status;

  fft_csr u_csr (
    .clk         (clk),
    .reset       (reset),
    .mmio_rx     (mmio_rx),
    .status      (hc_status),
    .mmio_tx     (mmio_tx),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .hc_buffer   (hc_buffer)
  );

  fft_job_ctrl u_job_ctrl (
    .clk         (clk),
    .reset       (reset),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .hc_buffer   (hc_buffer),
    .mem_rd_full (mem_rd_full),
    .mem_rd_rsp  (mem_rd_rsp),
    .mem_rd_req  (mem_rd_req),
    .mem_wr_req  (mem_wr_req),
    .status      (hc_status)
  );

endmodule

`default_nettype wire

// File: verification/fft_afu_chk.sv
// FFT engine channel protocol checker, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module fft_afu_chk (
  input logic                 clk,
  input logic                 reset,
  input fft_pkg::mmio_rx_t    mmio_rx,
  input fft_pkg::mmio_tx_t    mmio_tx,
  input logic                 mem_rd_full,
  input fft_pkg::mem_rd_req_t mem_rd_req,
  input fft_pkg::mem_wr_req_t mem_wr_req
);

  // Every host read answered on the next cycle with its tid
  a_mmio_rsp: assert property (@(posedge clk) disable iff (reset)
    mmio_rx.rd_valid |=> mmio_tx.rd_valid && (mmio_tx.tid == $past(mmio_rx.tid)))
    else $error("MMIO read response missing or tid mismatch");

  // No response without a request
  a_mmio_no_extra: assert property (@(posedge clk) disable iff (reset)
    mmio_tx.rd_valid |-> $past(mmio_rx.rd_valid))
    else $error("MMIO read response without a request");

  // Full level holds back the next read request
  a_rd_full: assert property (@(posedge clk) disable iff (reset)
    mem_rd_req.valid |-> !$past(mem_rd_full))
    else $error("read request issued while memory was full");

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !mmio_tx.rd_valid && !mem_rd_req.valid && !mem_wr_req.valid)
    else $error("valid output asserted during reset");

endmodule

bind fft_afu_top fft_afu_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .mmio_rx     (mmio_rx),
  .mmio_tx     (mmio_tx),
  .mem_rd_full (mem_rd_full),
  .mem_rd_req  (mem_rd_req),
  .mem_wr_req  (mem_wr_req)
);

`default_nettype wire

// File: verification/fft_afu_tb.sv
// FFT offload engine testbench with host MMIO model, random-latency memory and reference checks
`timescale 1ns/1ns
`default_nettype none

`include "fft_consts.svh"

module fft_afu_tb;

  localparam int MAX_LAT = 8;
  // All job lines, each may wait out the full latency plus stalls and MMIO setup
  localparam int JOB_LINES = 4 + 64 + 0;
  localparam int TIMEOUT_CYCLES = JOB_LINES * MAX_LAT * 32 + 2000;

  logic                 clk;
  logic                 reset;
  fft_pkg::mmio_rx_t    mmio_rx;
  fft_pkg::mmio_tx_t    mmio_tx;
  logic                 mem_rd_full;
  fft_pkg::mem_rd_rsp_t mem_rd_rsp;
  fft_pkg::mem_rd_req_t mem_rd_req;
  fft_pkg::mem_wr_req_t mem_wr_req;

  // Memory model state
  fft_pkg::line_t      mem_lines [fft_pkg::cl_addr_t];
  int                  rd_count [fft_pkg::cl_addr_t];
  int                  wr_count [fft_pkg::cl_addr_t];
  fft_pkg::line_tag_t  pend_tag [$];
  fft_pkg::line_t      pend_data [$];
  int                  pend_due [$];
  int                  mem_now;
  bit                  stall_en;
  bit                  completion_seen;
  fft_pkg::cl_addr_t   completion_addr;

  // Shadow of host writes
  logic [31:0]         sh_control;
  fft_pkg::mmio_data_t sh_dsm;
  fft_pkg::mmio_data_t sh_buf_addr [2];
  logic [31:0]         sh_buf_size [2];

  int test_errs;
  int total_errs;
  int pass_cnt;
  int fail_cnt;
  int cycles;

  fft_afu_top DUT (
    .clk         (clk),
    .reset       (reset),
    .mmio_rx     (mmio_rx),
    .mmio_tx     (mmio_tx),
    .mem_rd_full (mem_rd_full),
    .mem_rd_rsp  (mem_rd_rsp),
    .mem_rd_req  (mem_rd_req),
    .mem_wr_req  (mem_wr_req)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ====================
  // Memory model
  // ====================

  // Untouched lines carry their own address
  function automatic fft_pkg::line_t read_line(fft_pkg::cl_addr_t a);
    if (mem_lines.exists(a)) begin
      return mem_lines[a];
    end
    return {8{22'h15_a5a5, a}};
  endfunction

  always begin
    int idx;
    @(posedge clk);
    mem_now++;
    // Requests were set up during the cycle that just ended
    if (!reset && mem_rd_req.valid) begin
      if (rd_count.exists(mem_rd_req.address)) begin
        rd_count[mem_rd_req.address] = rd_count[mem_rd_req.address] + 1;
      end else begin
        rd_count[mem_rd_req.address] = 1;
      end
      pend_tag.push_back(mem_rd_req.tag);
      pend_data.push_back(read_line(mem_rd_req.address));
      pend_due.push_back(mem_now + int'($urandom_range(1, MAX_LAT)));
    end
    if (!reset && mem_wr_req.valid) begin
      mem_lines[mem_wr_req.address] = mem_wr_req.data;
      if (wr_count.exists(mem_wr_req.address)) begin
        wr_count[mem_wr_req.address] = wr_count[mem_wr_req.address] + 1;
      end else begin
        wr_count[mem_wr_req.address] = 1;
      end
      if (mem_wr_req.address == completion_addr) begin
        completion_seen = 1'b1;
      end
    end
    #1;
    // At most one response per cycle, first due entry wins so order varies
    mem_rd_rsp = '0;
    idx = -1;
    for (int i = 0; i < pend_due.size(); i++) begin
      if (idx < 0 && pend_due[i] <= mem_now) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      mem_rd_rsp.valid = 1'b1;
      mem_rd_rsp.tag = pend_tag[idx];
      mem_rd_rsp.data = pend_data[idx];
      pend_tag.delete(idx);
      pend_data.delete(idx);
      pend_due.delete(idx);
    end
    mem_rd_full = stall_en && ($urandom_range(0, 2) == 0);
  end

  // ====================
  // Reference and compare
  // ====================

  // Sum in the low eight samples, difference in the high eight
  function automatic fft_pkg::line_t ref_butterfly(fft_pkg::line_t x);
    fft_pkg::sample_t re [16];
    fft_pkg::sample_t im [16];
    fft_pkg::line_t   y;
    for (int k = 0; k < 16; k++) begin
      re[k] = x[32 * k +: 16];
      im[k] = x[32 * k + 16 +: 16];
    end
    for (int k = 0; k < 8; k++) begin
      y[32 * k +: 16] = re[k] + re[k + 8];
      y[32 * k + 16 +: 16] = im[k] + im[k + 8];
      y[32 * (k + 8) +: 16] = re[k] - re[k + 8];
      y[32 * (k + 8) + 16 +: 16] = im[k] - im[k + 8];
    end
    return y;
  endfunction

  function automatic fft_pkg::mmio_data_t ref_mmio_read(logic [15:0] off);
    case (off)
      `FFT_REG_DFH:       return (64'(`FFT_DFH_TYPE_AFU) << 60) | (64'd1 << `FFT_DFH_EOL_BIT);
      `FFT_REG_AFU_ID_L:  return `FFT_AFU_ID_LOW;
      `FFT_REG_AFU_ID_H:  return `FFT_AFU_ID_HIGH;
      `FFT_REG_CONTROL:   return {32'd0, sh_control};
      // Bytes in, lines out
      `FFT_REG_DSM_BASE:  return 64'(fft_pkg::cl_addr_t'(sh_dsm >> `FFT_DSM_LINE_SHIFT));
      `FFT_REG_BUF0_ADDR: return 64'(fft_pkg::cl_addr_t'(sh_buf_addr[0]));
      `FFT_REG_BUF0_SIZE: return {32'd0, sh_buf_size[0]};
      `FFT_REG_BUF1_ADDR: return 64'(fft_pkg::cl_addr_t'(sh_buf_addr[1]));
      `FFT_REG_BUF1_SIZE: return {32'd0, sh_buf_size[1]};
      default:            return '0;
    endcase
  endfunction

  function automatic fft_pkg::line_t random_line();
    fft_pkg::line_t l;
    for (int w = 0; w < 16; w++) begin
      l[32 * w +: 32] = $urandom;
    end
    return l;
  endfunction

  task automatic report_error(string msg);
    $display("[ERROR] %0t %s", $time, msg);
    test_errs++;
  endtask

  task automatic check_mmio(string name, fft_pkg::mmio_data_t got, fft_pkg::mmio_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_tid(string name, fft_pkg::tid_t got, fft_pkg::tid_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_line(string name, fft_pkg::line_t got, fft_pkg::line_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_status(string name, fft_pkg::hc_status_t got, fft_pkg::hc_status_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  // ====================
  // Host model
  // ====================

  task automatic mmio_write(logic [15:0] off, fft_pkg::mmio_data_t data);
    mmio_rx.wr_valid = 1'b1;
    mmio_rx.address = off >> 2;
    mmio_rx.data = data;
    @(posedge clk);
    #1;
    mmio_rx.wr_valid = 1'b0;
    case (off)
      `FFT_REG_CONTROL:   sh_control = data[31:0];
      `FFT_REG_DSM_BASE:  sh_dsm = data;
      `FFT_REG_BUF0_ADDR: sh_buf_addr[0] = data;
      `FFT_REG_BUF0_SIZE: sh_buf_size[0] = data[31:0];
      `FFT_REG_BUF1_ADDR: sh_buf_addr[1] = data;
      `FFT_REG_BUF1_SIZE: sh_buf_size[1] = data[31:0];
      default: ;
    endcase
  endtask

  // Random tid per request, response expected on the next cycle
  task automatic mmio_read(logic [15:0] off, output fft_pkg::mmio_data_t data);
    fft_pkg::tid_t tid;
    int            waited;
    tid = fft_pkg::tid_t'($urandom);
    waited = 0;
    mmio_rx.rd_valid = 1'b1;
    mmio_rx.address = off >> 2;
    mmio_rx.tid = tid;
    @(posedge clk);
    #1;
    mmio_rx.rd_valid = 1'b0;
    while (!mmio_tx.rd_valid && waited < 4) begin
      @(posedge clk);
      #1;
      waited++;
    end
    data = mmio_tx.data;
    if (!mmio_tx.rd_valid) begin
      report_error($sformatf("no MMIO read response for offset %h", off));
    end else begin
      check_tid("mmio_tx.tid", mmio_tx.tid, tid);
    end
  endtask

  task automatic compare_read(string name, logic [15:0] off);
    fft_pkg::mmio_data_t rd;
    mmio_read(off, rd);
    check_mmio(name, rd, ref_mmio_read(off));
  endtask

  task automatic end_test(string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %-16s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-16s FAILED with %0d errors", name, test_errs);
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // One job from descriptor setup through completion and status
  task automatic run_job(int n, fft_pkg::cl_addr_t in_base, fft_pkg::cl_addr_t out_base,
                         fft_pkg::mmio_data_t dsm_bytes, bit stall);
    fft_pkg::cl_addr_t   a;
    fft_pkg::mmio_data_t rd;
    fft_pkg::hc_status_t exp_st;
    for (int i = 0; i < n; i++) begin
      mem_lines[in_base + fft_pkg::cl_addr_t'(i)] = random_line();
    end
    rd_count.delete();
    wr_count.delete();
    completion_addr = fft_pkg::cl_addr_t'(dsm_bytes >> `FFT_DSM_LINE_SHIFT);
    completion_seen = 1'b0;
    mmio_write(`FFT_REG_BUF0_ADDR, 64'(in_base));
    mmio_write(`FFT_REG_BUF0_SIZE, 64'(n));
    mmio_write(`FFT_REG_BUF1_ADDR, 64'(out_base));
    mmio_write(`FFT_REG_BUF1_SIZE, 64'(n));
    mmio_write(`FFT_REG_DSM_BASE, dsm_bytes);
    mmio_write(`FFT_REG_CONTROL, 64'd0);
    stall_en = stall;
    mmio_write(`FFT_REG_CONTROL, 64'd1);
    // Completion record ends the job
    while (!completion_seen) begin
      @(posedge clk);
      #1;
    end
    stall_en = 1'b0;
    for (int i = 0; i < n; i++) begin
      a = in_base + fft_pkg::cl_addr_t'(i);
      if (!rd_count.exists(a) || rd_count[a] != 1) begin
        report_error($sformatf("input line %0d requested %0d times", i,
                               rd_count.exists(a) ? rd_count[a] : 0));
      end
      a = out_base + fft_pkg::cl_addr_t'(i);
      if (!wr_count.exists(a) || wr_count[a] != 1) begin
        report_error($sformatf("output line %0d not written exactly once", i));
      end else begin
        check_line($sformatf("output line %0d", i), mem_lines[a],
                   ref_butterfly(mem_lines[in_base + fft_pkg::cl_addr_t'(i)]));
      end
    end
    if (rd_count.num() != n) begin
      report_error($sformatf("%0d distinct lines read for a %0d-line job", rd_count.num(), n));
    end
    if (wr_count.num() != n + 1) begin
      report_error($sformatf("%0d distinct lines written for a %0d-line job", wr_count.num(), n));
    end
    // Done flag low, line count above it
    check_line("completion line", mem_lines[completion_addr],
               fft_pkg::line_t'({32'(n), 32'd1}));
    mmio_read(`FFT_REG_STATUS, rd);
    exp_st = '0;
    exp_st.busy = 1'b0;
    exp_st.done = 1'b1;
    exp_st.lines_done = 32'(n);
    check_status("status", fft_pkg::hc_status_t'(rd), exp_st);
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    fft_pkg::mmio_data_t rd;
    void'($urandom(32'h5c5d6fdc));
    reset = 1'b1;
    mmio_rx = '0;
    mem_rd_full = 1'b0;
    mem_rd_rsp = '0;
    stall_en = 1'b0;
    completion_seen = 1'b0;
    completion_addr = '1;
    mem_now = 0;
    cycles = 0;
    test_errs = 0;
    total_errs = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    sh_control = '0;
    sh_dsm = '0;
    sh_buf_addr[0] = '0;
    sh_buf_addr[1] = '0;
    sh_buf_size[0] = '0;
    sh_buf_size[1] = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    compare_read("dfh", `FFT_REG_DFH);
    compare_read("afu_id_l", `FFT_REG_AFU_ID_L);
    compare_read("afu_id_h", `FFT_REG_AFU_ID_H);
    compare_read("reserved 0x018", 16'h018);
    compare_read("unmapped 0x400", 16'h400);
    mmio_read(`FFT_REG_STATUS, rd);
    check_status("status after reset", fft_pkg::hc_status_t'(rd), '0);
    end_test("feature_list");

    // Start bit stays clear, upper bits check the field widths
    mmio_write(`FFT_REG_CONTROL, 64'hdead_beef_5a5a_a5a4);
    mmio_write(`FFT_REG_DSM_BASE, 64'h0000_1234_5678_9ac0);
    mmio_write(`FFT_REG_BUF0_ADDR, 64'hffff_f123_4567_89ab);
    mmio_write(`FFT_REG_BUF0_SIZE, 64'h0000_0001_0000_0010);
    mmio_write(`FFT_REG_BUF1_ADDR, 64'h0000_0000_0bad_cafe);
    mmio_write(`FFT_REG_BUF1_SIZE, 64'h8000_0000_ffff_fff0);
    compare_read("control", `FFT_REG_CONTROL);
    compare_read("dsm_base", `FFT_REG_DSM_BASE);
    compare_read("buf0_addr", `FFT_REG_BUF0_ADDR);
    compare_read("buf0_size", `FFT_REG_BUF0_SIZE);
    compare_read("buf1_addr", `FFT_REG_BUF1_ADDR);
    compare_read("buf1_size", `FFT_REG_BUF1_SIZE);
    end_test("config_readback");

    run_job(4, 42'h100, 42'h200, 64'h0010_0000, 1'b0);
    end_test("job_4_lines");
    run_job(64, 42'h1000, 42'h2000, 64'h0030_0000, 1'b1);
    end_test("job_64_stalled");
    run_job(0, 42'h3000, 42'h4000, 64'h0050_0000, 1'b0);
    end_test("job_0_lines");

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, total_errs);
    if (total_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/fft_pkg.sv
src/fft_butterfly.sv
src/fft_csr.sv
src/fft_job_ctrl.sv
src/fft_afu_top.sv
verification/fft_afu_chk.sv
verification/fft_afu_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := fft_afu_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) src/fft_consts.svh
FAIL_MSG  := >>> FAIL
PASS_MSG  := >>> PASS

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q -F '$(PASS_MSG)' $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
